// ==== logic/periph_macros.svh ====
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// Memory sizes in nibbles
`define RAM_WORDS 640
`define DISPLAY_WORDS 160

// Upper display window lands after the lower one in display RAM
`define DISPLAY_UPPER_OFFSET 80

// Address windows, end bounds exclusive
`define RAM_END 12'h280
`define DISP_LO_BASE 12'hE00
`define DISP_LO_END 12'hE50
`define DISP_HI_BASE 12'hE80
`define DISP_HI_END 12'hED0

// Top nibble of every I/O register address
`define IO_PAGE 4'hF

`endif

// ==== logic/periph_pkg.sv ====
package periph_pkg;

  // Core data bus is one nibble wide, addresses are 12 bits
  typedef logic [11:0] addr_t;
  typedef logic [3:0] nibble_t;
  typedef logic [7:0] disp_index_t;

  // Low address byte of the I/O registers inside page 0xF
  typedef enum logic [7:0] {
    CLOCK_FACTOR = 8'h00,
    K0_FACTOR    = 8'h04,
    K1_FACTOR    = 8'h05,
    CLOCK_MASK   = 8'h10,
    K0_MASK      = 8'h14,
    K1_MASK      = 8'h15,
    TIMER_LOW    = 8'h20,
    TIMER_HIGH   = 8'h21,
    K0_VALUE     = 8'h40,
    K0_RELATION  = 8'h41,
    K1_VALUE     = 8'h42,
    TIMER_RESET  = 8'h76
  } io_reg_e;

endpackage

// ==== logic/periph_target_if.sv ====
`timescale 1ns/1ps

// One decoded access from the bus controller to a memory target
interface periph_target_if;
  logic write;
  logic read;
  // Offset inside the target, already rebased by the controller
  periph_pkg::addr_t index;
  periph_pkg::nibble_t write_data;
  periph_pkg::nibble_t read_data;

  modport ctrl (
    output write,
    output read,
    output index,
    output write_data,
    input read_data
  );

  modport target (
    input write,
    input read,
    input index,
    input write_data,
    output read_data
  );
endinterface

// ==== logic/bus_controller.sv ====
`timescale 1ns/1ps
`include "periph_macros.svh"

module bus_controller (
  input logic clk,
  input logic reset_n,
  input logic clk_en,
  input logic bus_write_en,
  input logic bus_read_en,
  input periph_pkg::addr_t bus_addr,
  input periph_pkg::nibble_t bus_write_data,
  output periph_pkg::nibble_t bus_read_data,
  input periph_pkg::nibble_t input_k0,
  input periph_pkg::nibble_t input_k1,
  input logic [7:0] count,
  input logic [1:0] input_factor,
  input periph_pkg::nibble_t clock_factor,
  periph_target_if.ctrl ram_bus,
  periph_target_if.ctrl disp_bus,
  output logic timer_reset,
  output periph_pkg::nibble_t clock_mask,
  output periph_pkg::nibble_t k0_mask,
  output periph_pkg::nibble_t k1_mask,
  output periph_pkg::nibble_t relation,
  output logic input_clear,
  output logic clock_clear
);
  logic write_access;
  logic read_access;
  logic in_ram;
  logic in_disp_lo;
  logic in_disp_hi;
  logic in_io;
  logic io_write;
  logic io_read;
  periph_pkg::io_reg_e io_reg;
  periph_pkg::nibble_t io_value;
  periph_pkg::nibble_t read_value;

  // A cycle with both enables set is not an access
  assign write_access = clk_en & bus_write_en & ~bus_read_en;
  assign read_access = clk_en & bus_read_en & ~bus_write_en;

  // Window decode
  assign in_ram = bus_addr < `RAM_END;
  assign in_disp_lo = (bus_addr >= `DISP_LO_BASE) && (bus_addr < `DISP_LO_END);
  assign in_disp_hi = (bus_addr >= `DISP_HI_BASE) && (bus_addr < `DISP_HI_END);
  assign in_io = bus_addr[11:8] == `IO_PAGE;

  assign io_reg = periph_pkg::io_reg_e'(bus_addr[7:0]);
  assign io_write = write_access & in_io;
  assign io_read = read_access & in_io;

  // Work RAM target
  assign ram_bus.write = write_access & in_ram;
  assign ram_bus.read = read_access & in_ram;
  assign ram_bus.index = bus_addr;
  assign ram_bus.write_data = bus_write_data;

  // Both display windows share one RAM, upper window after the lower one
  assign disp_bus.write = write_access & (in_disp_lo | in_disp_hi);
  assign disp_bus.read = read_access & (in_disp_lo | in_disp_hi);
  assign disp_bus.index = in_disp_hi ?
      bus_addr - `DISP_HI_BASE + periph_pkg::addr_t'(`DISPLAY_UPPER_OFFSET) :
      bus_addr - `DISP_LO_BASE;
  assign disp_bus.write_data = bus_write_data;

  // I/O read mux and the one-cycle pulses, which act on the access edge
  always_comb begin
    io_value = '0;
    timer_reset = 1'b0;
    clock_clear = 1'b0;
    input_clear = 1'b0;
    case (io_reg)
      periph_pkg::CLOCK_FACTOR: begin
        io_value = clock_factor;
        clock_clear = io_read;
      end
      periph_pkg::K0_FACTOR: begin
        io_value = {3'b000, input_factor[0]};
        input_clear = io_read;
      end
      periph_pkg::K1_FACTOR: begin
        io_value = {3'b000, input_factor[1]};
        input_clear = io_read;
      end
      periph_pkg::CLOCK_MASK: io_value = clock_mask;
      periph_pkg::K0_MASK: io_value = k0_mask;
      periph_pkg::K1_MASK: io_value = k1_mask;
      periph_pkg::TIMER_LOW: io_value = count[3:0];
      periph_pkg::TIMER_HIGH: io_value = count[7:4];
      periph_pkg::K0_VALUE: io_value = input_k0;
      periph_pkg::K0_RELATION: io_value = relation;
      periph_pkg::K1_VALUE: io_value = input_k1;
      // Bit 1 of the write data restarts the clock timer
      periph_pkg::TIMER_RESET: timer_reset = io_write & bus_write_data[1];
      default: io_value = '0;
    endcase
  end

  always_comb begin
    if (in_ram) begin
      read_value = ram_bus.read_data;
    end else if (in_disp_lo || in_disp_hi) begin
      read_value = disp_bus.read_data;
    end else if (in_io) begin
      read_value = io_value;
    end else begin
      read_value = '0;
    end
  end

  // Writable I/O registers
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      clock_mask <= '0;
      k0_mask <= '0;
      k1_mask <= '0;
      relation <= 4'hF;
    end else if (io_write) begin
      case (io_reg)
        periph_pkg::CLOCK_MASK: clock_mask <= bus_write_data;
        periph_pkg::K0_MASK: k0_mask <= bus_write_data;
        periph_pkg::K1_MASK: k1_mask <= bus_write_data;
        periph_pkg::K0_RELATION: relation <= bus_write_data;
        default: ;
      endcase
    end
  end

  // Read data register, zero after any cycle that was not a read
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      bus_read_data <= '0;
    end else if (clk_en) begin
      bus_read_data <= read_access ? read_value : '0;
    end
  end
endmodule

// ==== logic/work_ram.sv ====
`timescale 1ns/1ps
`include "periph_macros.svh"

module work_ram (
  input logic clk,
  periph_target_if.target bus
);
  localparam int INDEX_BITS = $clog2(`RAM_WORDS);

  periph_pkg::nibble_t mem [`RAM_WORDS];
  logic [INDEX_BITS-1:0] word_index;

  // Controller only selects this target inside the RAM window
  assign word_index = bus.index[INDEX_BITS-1:0];

  always_ff @(posedge clk) begin
    if (bus.write) begin
      mem[word_index] <= bus.write_data;
    end
  end

  // Asynchronous read, controller registers it
  assign bus.read_data = bus.read ? mem[word_index] : '0;
endmodule

// ==== logic/display_ram.sv ====
`timescale 1ns/1ps
`include "periph_macros.svh"

module display_ram (
  input logic clk,
  periph_target_if.target bus,
  input periph_pkg::disp_index_t video_addr,
  output periph_pkg::nibble_t video_data
);
  localparam int INDEX_BITS = $clog2(`DISPLAY_WORDS);

  periph_pkg::nibble_t mem [`DISPLAY_WORDS];
  logic [INDEX_BITS-1:0] word_index;

  // Lower window at 0, upper window already offset by the controller
  assign word_index = bus.index[INDEX_BITS-1:0];

  always_ff @(posedge clk) begin
    if (bus.write) begin
      mem[word_index] <= bus.write_data;
    end
  end

  assign bus.read_data = bus.read ? mem[word_index] : '0;

  // Video port, one cycle latency
  always_ff @(posedge clk) begin
    if (video_addr < `DISPLAY_WORDS) begin
      video_data <= mem[video_addr];
    end else begin
      video_data <= '0;
    end
  end
endmodule

// ==== logic/clock_timer.sv ====
`timescale 1ns/1ps

module clock_timer (
  input logic clk,
  input logic reset_n,
  input logic clk_en,
  input logic timer_reset,
  output logic [7:0] count,
  output logic [3:0] stage_falls
);
  logic increment;
  logic [7:0] next_count;
  logic [7:0] falls;

  // Bit 0 is the 128 Hz stage, bit 7 the 1 Hz stage
  assign increment = clk_en & ~timer_reset;
  assign next_count = count + 8'd1;
  assign falls = count & ~next_count;

  // 32 Hz, 8 Hz, 2 Hz and 1 Hz stages drive the clock factors
  assign stage_falls = increment ? {falls[7], falls[6], falls[4], falls[2]} : 4'b0000;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      count <= '0;
    end else if (timer_reset) begin
      count <= '0;
    end else if (clk_en) begin
      count <= next_count;
    end
  end
endmodule

// ==== logic/input_port.sv ====
`timescale 1ns/1ps

module input_port (
  input logic clk,
  input logic reset_n,
  input logic clk_en,
  input periph_pkg::nibble_t input_k0,
  input periph_pkg::nibble_t input_k1,
  input periph_pkg::nibble_t k0_mask,
  input periph_pkg::nibble_t k1_mask,
  input periph_pkg::nibble_t relation,
  input logic input_clear,
  output logic [1:0] input_factor
);
  periph_pkg::nibble_t k0_sample;
  periph_pkg::nibble_t k0_last;
  periph_pkg::nibble_t k1_sample;
  periph_pkg::nibble_t k1_last;
  logic k0_event;
  logic k1_event;

  // Lines idle high, so start from all ones
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      k0_sample <= 4'hF;
      k0_last <= 4'hF;
      k1_sample <= 4'hF;
      k1_last <= 4'hF;
    end else if (clk_en) begin
      k0_last <= k0_sample;
      k0_sample <= input_k0;
      k1_last <= k1_sample;
      k1_sample <= input_k1;
    end
  end

  // K0 fires when a masked bit changes to the level opposite its relation bit
  assign k0_event = |((k0_sample ^ k0_last) & (k0_sample ^ relation) & k0_mask);
  // K1 fires on a masked falling edge only
  assign k1_event = |(k1_last & ~k1_sample & k1_mask);

  // A new event beats a clear on the same edge
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      input_factor <= 2'b00;
    end else begin
      input_factor <= (input_factor & ~{2{input_clear}}) |
                      ({k1_event, k0_event} & {2{clk_en}});
    end
  end
endmodule

// ==== logic/interrupt_unit.sv ====
`timescale 1ns/1ps

module interrupt_unit (
  input logic clk,
  input logic reset_n,
  input logic [3:0] stage_falls,
  input periph_pkg::nibble_t clock_mask,
  input logic clock_clear,
  input logic [1:0] input_factor,
  output periph_pkg::nibble_t clock_factor,
  output logic [2:0] interrupt_req
);
  logic clock_pending;

  // Factors latch stage falls, a factor read clears all four
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      clock_factor <= '0;
    end else begin
      clock_factor <= (clock_factor & ~{4{clock_clear}}) | stage_falls;
    end
  end

  // Mask only gates the request, factor bits set regardless
  assign clock_pending = |(clock_factor & clock_mask);

  // K0 and K1 factors are masked at the input port already
  assign interrupt_req = {input_factor[1], input_factor[0], clock_pending};
endmodule

// ==== logic/mcu_peripherals.sv ====
`timescale 1ns/1ps

module mcu_peripherals (
  input logic clk,
  input logic reset_n,
  input logic clk_en,
  input logic bus_write_en,
  input logic bus_read_en,
  input periph_pkg::addr_t bus_addr,
  input periph_pkg::nibble_t bus_write_data,
  output periph_pkg::nibble_t bus_read_data,
  input periph_pkg::nibble_t input_k0,
  input periph_pkg::nibble_t input_k1,
  input periph_pkg::disp_index_t video_addr,
  output periph_pkg::nibble_t video_data,
  output logic [2:0] interrupt_req
);
  logic [7:0] count;
  logic [3:0] stage_falls;
  logic timer_reset;
  periph_pkg::nibble_t clock_mask;
  periph_pkg::nibble_t k0_mask;
  periph_pkg::nibble_t k1_mask;
  periph_pkg::nibble_t relation;
  periph_pkg::nibble_t clock_factor;
  logic input_clear;
  logic clock_clear;
  logic [1:0] input_factor;

  periph_target_if ram_bus ();
  periph_target_if disp_bus ();

  bus_controller bus_controller_i (
    .clk(clk),
    .reset_n(reset_n),
    .clk_en(clk_en),
    .bus_write_en(bus_write_en),
    .bus_read_en(bus_read_en),
    .bus_addr(bus_addr),
    .bus_write_data(bus_write_data),
    .bus_read_data(bus_read_data),
    .input_k0(input_k0),
    .input_k1(input_k1),
    .count(count),
    .input_factor(input_factor),
    .clock_factor(clock_factor),
    .ram_bus(ram_bus.ctrl),
    .disp_bus(disp_bus.ctrl),
    .timer_reset(timer_reset),
    .clock_mask(clock_mask),
    .k0_mask(k0_mask),
    .k1_mask(k1_mask),
    .relation(relation),
    .input_clear(input_clear),
    .clock_clear(clock_clear)
  );

  work_ram work_ram_i (
    .clk(clk),
    .bus(ram_bus.target)
  );

  // Video reads run on the core clock
  display_ram display_ram_i (
    .clk(clk),
    .bus(disp_bus.target),
    .video_addr(video_addr),
    .video_data(video_data)
  );

  clock_timer clock_timer_i (
    .clk(clk),
    .reset_n(reset_n),
    .clk_en(clk_en),
    .timer_reset(timer_reset),
    .count(count),
    .stage_falls(stage_falls)
  );

  input_port input_port_i (
    .clk(clk),
    .reset_n(reset_n),
    .clk_en(clk_en),
    .input_k0(input_k0),
    .input_k1(input_k1),
    .k0_mask(k0_mask),
    .k1_mask(k1_mask),
    .relation(relation),
    .input_clear(input_clear),
    .input_factor(input_factor)
  );

  interrupt_unit interrupt_unit_i (
    .clk(clk),
    .reset_n(reset_n),
    .stage_falls(stage_falls),
    .clock_mask(clock_mask),
    .clock_clear(clock_clear),
    .input_factor(input_factor),
    .clock_factor(clock_factor),
    .interrupt_req(interrupt_req)
  );
endmodule

// ==== verification/mcu_peripherals_tb.sv ====
`timescale 1ns/1ps

module mcu_peripherals_tb;
  // Polls run every 2 ns, so this allows 16 ns for one rising edge
  localparam int EDGE_POLL_LIMIT = 8;

  logic clk = 1'b0;
  logic reset_n;
  logic clk_en;
  logic bus_write_en;
  logic bus_read_en;
  periph_pkg::addr_t bus_addr;
  periph_pkg::nibble_t bus_write_data;
  periph_pkg::nibble_t bus_read_data;
  periph_pkg::nibble_t input_k0;
  periph_pkg::nibble_t input_k1;
  periph_pkg::disp_index_t video_addr;
  periph_pkg::nibble_t video_data;
  logic [2:0] interrupt_req;
  int unsigned edge_count = 0;

  mcu_peripherals mcu_peripherals_i (
    .clk(clk),
    .reset_n(reset_n),
    .clk_en(clk_en),
    .bus_write_en(bus_write_en),
    .bus_read_en(bus_read_en),
    .bus_addr(bus_addr),
    .bus_write_data(bus_write_data),
    .bus_read_data(bus_read_data),
    .input_k0(input_k0),
    .input_k1(input_k1),
    .video_addr(video_addr),
    .video_data(video_data),
    .interrupt_req(interrupt_req)
  );

  // 4 ns period
  always #2 clk = ~clk;

  always @(posedge clk) begin
    edge_count <= edge_count + 1;
  end

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic compare_nibble(string name, periph_pkg::nibble_t actual,
                                periph_pkg::nibble_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("Fail at %0d ns: %s is %h, expected %h",
                          $time, name, actual, expected));
    end
  endtask

  // Called 1 ns after an edge, returns 1 ns after the next one
  task automatic next_cycle();
    int unsigned start_count;
    int polls;
    start_count = edge_count;
    polls = 0;
    while (edge_count == start_count) begin
      if (polls == EDGE_POLL_LIMIT) begin
        abort_run($sformatf("No rising clock edge within %0d ns", 2 * EDGE_POLL_LIMIT));
      end
      #2;
      polls++;
    end
  endtask

  task automatic bus_write(periph_pkg::addr_t addr, periph_pkg::nibble_t data);
    bus_addr = addr;
    bus_write_data = data;
    bus_write_en = 1'b1;
    next_cycle();
    bus_write_en = 1'b0;
  endtask

  // Read data is registered on the access edge
  task automatic bus_read_check(periph_pkg::addr_t addr, periph_pkg::nibble_t expected);
    bus_addr = addr;
    bus_read_en = 1'b1;
    next_cycle();
    bus_read_en = 1'b0;
    compare_nibble("bus_read_data", bus_read_data, expected);
  endtask

  task automatic video_read_check(periph_pkg::disp_index_t index,
                                  periph_pkg::nibble_t expected);
    video_addr = index;
    next_cycle();
    compare_nibble("video_data", video_data, expected);
  endtask

  task automatic run_operation(logic [7:0] op, logic [11:0] arg_a, logic [11:0] arg_b,
                               logic [11:0] expected, int line_no);
    case (op)
      "W": bus_write(arg_a, arg_b[3:0]);
      "R": bus_read_check(arg_a, expected[3:0]);
      "I": repeat (arg_a) next_cycle();
      "K": begin
        input_k0 = arg_a[3:0];
        input_k1 = arg_b[3:0];
      end
      "V": video_read_check(arg_a[7:0], expected[3:0]);
      "Q": compare_nibble("interrupt_req", {1'b0, interrupt_req}, expected[3:0]);
      default: abort_run($sformatf("Unknown operation on stimulus line %0d", line_no));
    endcase
  endtask

  initial begin
    int fd;
    int fields;
    int line_no;
    int op_count;
    string line;
    logic [7:0] op;
    logic [11:0] arg_a;
    logic [11:0] arg_b;
    logic [11:0] expected;

    reset_n = 1'b0;
    clk_en = 1'b1;
    bus_write_en = 1'b0;
    bus_read_en = 1'b0;
    bus_addr = '0;
    bus_write_data = '0;
    // K lines idle high
    input_k0 = 4'hF;
    input_k1 = 4'hF;
    video_addr = '0;
    line_no = 0;
    op_count = 0;

    fd = $fopen("verification/periph_stim.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open the stimulus file verification/periph_stim.txt");
    end

    // Reset covers the edges at 2 ns and 6 ns
    #3;
    next_cycle();
    reset_n = 1'b1;

    while ($fgets(line, fd) != 0) begin
      line_no++;
      if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
        continue;
      end
      fields = $sscanf(line, "%c %h %h %h", op, arg_a, arg_b, expected);
      if (fields != 4) begin
        abort_run($sformatf("Malformed stimulus line %0d", line_no));
      end
      run_operation(op, arg_a, arg_b, expected, line_no);
      op_count++;
    end
    $fclose(fd);

    if (op_count > 0) begin
      $display("sim passed");
      $finish;
    end else begin
      abort_run("The stimulus file held no operations");
    end
  end
endmodule

// ==== verification/periph_stim.txt ====
# op addr_or_value data expected, all fields hex
# W write, R read, I idle cycles, K drive K0 and K1, V video read, Q interrupt_req
# Values after reset
R F10 0 0
R F14 0 0
R F15 0 0
R F41 0 F
Q 0 0 0
# Mask and relation registers
W F10 5 0
R F10 0 5
W F14 A 0
R F14 0 A
Q 0 0 1
W F15 3 0
R F15 0 3
W F41 6 0
R F41 0 6
W F10 0 0
Q 0 0 0
W F14 0 0
W F15 0 0
W F41 F 0
# First clock factor read clears the earlier flags
R F00 0 1
W F10 1 0
W F76 2 0
I A 0 0
Q 0 0 1
R F00 0 1
R F00 0 0
Q 0 0 0
W F10 0 0
# Timer reads count the edges since the reset write
W F76 2 0
I 13 0 0
R F20 0 3
R F21 0 1
W F76 1 0
R F20 0 6
# Work RAM and unmapped space
W 000 3 0
W 27F C 0
W 280 7 0
R 000 0 3
R 27F 0 C
R 280 0 0
R D00 0 0
R F30 0 0
# Display windows on the bus and the video port
W E00 1 0
W E4F 2 0
W E85 E 0
W ECF 8 0
R E00 0 1
R E4F 0 2
R E85 0 E
R ECF 0 8
V 00 0 1
V 4F 0 2
V 55 0 E
V 9F 0 8
V A0 0 0
# Input levels and factors
K 5 A 0
R F40 0 5
R F42 0 A
K F F 0
I 2 0 0
W F14 1 0
K 7 F 0
I 3 0 0
Q 0 0 0
K 6 F 0
I 2 0 0
Q 0 0 2
R F04 0 1
Q 0 0 0
W F15 1 0
K 7 E 0
I 2 0 0
Q 0 0 4
K 6 E 0
I 2 0 0
Q 0 0 6
R F05 0 1
Q 0 0 0
R F04 0 0
# Relation bit 0 cleared so a rise on K0 bit 0 counts
W F41 E 0
K 7 E 0
I 2 0 0
Q 0 0 2
R F04 0 1
R F41 0 E

// ==== verilog.f ====
+incdir+logic
logic/periph_pkg.sv
logic/periph_target_if.sv
logic/bus_controller.sv
logic/work_ram.sv
logic/display_ram.sv
logic/clock_timer.sv
logic/input_port.sv
logic/interrupt_unit.sv
logic/mcu_peripherals.sv
verification/mcu_peripherals_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing -f verilog.f --top-module mcu_peripherals_tb -o mcu_peripherals_tb &&
./obj_dir/mcu_peripherals_tb || exit 1
